// File: src/audio_mix_pkg.sv
////////////////////////////////////////////////////////////
// Audio mixer shared definitions
// Sample formats, cross-mix modes and host command opcodes
////////////////////////////////////////////////////////////

package audio_mix_pkg;

	// Sample and attenuation field widths
	localparam int SAMPLE_W = 16;
	localparam int ATT_W    = 5;

	// Stereo sample pair as carried on the ports
	typedef struct packed {
		logic [SAMPLE_W-1:0] l;
		logic [SAMPLE_W-1:0] r;
	} stereo_t;

	// Signed intermediate pair with one bit of headroom
	typedef struct packed {
		logic signed [SAMPLE_W:0] l;
		logic signed [SAMPLE_W:0] r;
	} wide_stereo_t;

	// Cross-channel blend amount
	typedef enum logic [1:0] {
		MIX_NONE    = 2'd0,
		MIX_QUARTER = 2'd1,
		MIX_HALF    = 2'd2,
		MIX_MONO    = 2'd3
	} mix_mode_e;

	// Host command opcodes, low byte of the first word in a frame
	typedef enum logic [7:0] {
		CMD_NONE   = 8'h00,
		CMD_VOLUME = 8'h26
	} cmd_e;

endpackage

// File: src/volume_cmd_decoder.sv
////////////////////////////////////////////////////////////
// Volume command decoder
// Follows the select-framed host word stream and keeps the
// attenuation value written by the volume command
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module volume_cmd_decoder import audio_mix_pkg::*; (
	input  logic             clk,
	input  logic             resetd,
	input  logic             i_cmd_sel,
	input  logic             i_cmd_strobe,
	input  logic [15:0]      i_cmd_data,
	output logic [ATT_W-1:0] o_att
);

	typedef enum logic {
		DEC_IDLE,
		DEC_CMD
	} dec_state_e;

	dec_state_e state;
	cmd_e       opcode;

	////////////////////////////////////////////////////////////
	// Frame FSM
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (resetd) begin
			state  <= DEC_IDLE;
			opcode <= CMD_NONE;
			o_att  <= '0;
		end else if (!i_cmd_sel) begin
			// Deselect closes the frame
			state <= DEC_IDLE;
		end else if (i_cmd_strobe) begin
			case (state)
				DEC_IDLE: begin
					// First word of a frame is the opcode
					opcode <= cmd_e'(i_cmd_data[7:0]);
					state  <= DEC_CMD;
				end
				DEC_CMD: begin
					// Every data word reloads the setting
					if (opcode == CMD_VOLUME) begin
						o_att <= i_cmd_data[ATT_W-1:0];
					end
				end
				default: begin
					state <= DEC_IDLE;
				end
			endcase
		end
	end

endmodule

// File: src/sample_stabilizer.sv
////////////////////////////////////////////////////////////
// Sample stabilizer
// Lets a core sample through only after it repeats
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module sample_stabilizer import audio_mix_pkg::*; (
	input  logic    clk,
	input  logic    resetd,
	input  logic    i_valid,
	input  stereo_t i_core,
	output logic    o_valid,
	output stereo_t o_core
);

	// Last strobed sample and last accepted sample
	stereo_t prev;
	stereo_t held;

	always_ff @(posedge clk) begin
		if (resetd) begin
			prev    <= '0;
			held    <= '0;
			o_valid <= 1'b0;
		end else begin
			o_valid <= i_valid;
			if (i_valid) begin
				prev <= i_core;
				// Single-sample glitches never match prev
				if (i_core.l == prev.l) begin
					held.l <= i_core.l;
				end
				if (i_core.r == prev.r) begin
					held.r <= i_core.r;
				end
			end
		end
	end

	assign o_core = held;

endmodule

// File: src/source_summer.sv
////////////////////////////////////////////////////////////
// Source summer
// Widens core samples by signedness and adds host PCM
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module source_summer import audio_mix_pkg::*; (
	input  logic         clk,
	input  logic         resetd,
	input  logic         i_valid,
	input  stereo_t      i_core,
	input  logic         i_core_signed,
	input  stereo_t      i_host,
	output logic         o_valid,
	output wide_stereo_t o_sum
);

	function automatic logic signed [SAMPLE_W:0] sum_channel(
		input logic [SAMPLE_W-1:0] core,
		input logic [SAMPLE_W-1:0] host,
		input logic                is_signed
	);
		logic signed [SAMPLE_W:0] core_w;
		logic signed [SAMPLE_W:0] host_w;
		// Unsigned core loses its LSB to stay non-negative
		if (is_signed) begin
			core_w = {core[SAMPLE_W-1], core};
		end else begin
			core_w = {2'b00, core[SAMPLE_W-1:1]};
		end
		host_w = {host[SAMPLE_W-1], host};
		return core_w + host_w;
	endfunction

	always_ff @(posedge clk) begin
		if (resetd) begin
			o_valid <= 1'b0;
		end else begin
			o_valid <= i_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (i_valid) begin
			o_sum.l <= sum_channel(i_core.l, i_host.l, i_core_signed);
			o_sum.r <= sum_channel(i_core.r, i_host.r, i_core_signed);
		end
	end

endmodule

// File: src/cross_mixer.sv
////////////////////////////////////////////////////////////
// Cross mixer
// Blends each channel with half of the opposite channel
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module cross_mixer import audio_mix_pkg::*; (
	input  logic         clk,
	input  logic         resetd,
	input  logic         i_valid,
	input  wide_stereo_t i_sum,
	input  mix_mode_e    i_mix,
	output logic         o_valid,
	output wide_stereo_t o_mixed
);

	function automatic logic signed [SAMPLE_W:0] mix_channel(
		input logic signed [SAMPLE_W:0] own,
		input logic signed [SAMPLE_W:0] opp,
		input mix_mode_e                mode
	);
		logic signed [SAMPLE_W:0] other;
		logic signed [SAMPLE_W:0] res;
		// Opposite channel enters at half level
		other = opp >>> 1;
		case (mode)
			MIX_QUARTER: res = own - (own >>> 3) + (other >>> 2);
			MIX_HALF:    res = own - (own >>> 2) + (other >>> 1);
			MIX_MONO:    res = (own >>> 1) + other;
			default:     res = own;
		endcase
		return res;
	endfunction

	////////////////////////////////////////////////////////////
	// Pipeline register
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (resetd) begin
			o_valid <= 1'b0;
		end else begin
			o_valid <= i_valid;
		end
	end

	// Wraps to 17 bits and leaves overflow to the clamp stage
	always_ff @(posedge clk) begin
		if (i_valid) begin
			o_mixed.l <= mix_channel(i_sum.l, i_sum.r, i_mix);
			o_mixed.r <= mix_channel(i_sum.r, i_sum.l, i_mix);
		end
	end

endmodule

// File: src/volume_clamp.sv
////////////////////////////////////////////////////////////
// Volume and clamp
// Shift-based attenuation with mute, then 16-bit saturation
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module volume_clamp import audio_mix_pkg::*; (
	input  logic             clk,
	input  logic             resetd,
	input  logic             i_valid,
	input  wide_stereo_t     i_mixed,
	input  logic [ATT_W-1:0] i_att,
	output logic             o_valid,
	output stereo_t          o_audio
);

	logic         att_valid;
	wide_stereo_t att_data;

	function automatic logic signed [SAMPLE_W:0] attenuate(
		input logic signed [SAMPLE_W:0] v,
		input logic [ATT_W-1:0]         att
	);
		// Top bit of att is mute
		if (att[ATT_W-1]) begin
			return '0;
		end
		return v >>> att[ATT_W-2:0];
	endfunction

	function automatic logic [SAMPLE_W-1:0] saturate(
		input logic signed [SAMPLE_W:0] v
	);
		// Top two bits disagree means out of 16-bit range
		if (v[SAMPLE_W] != v[SAMPLE_W-1]) begin
			return {v[SAMPLE_W], {(SAMPLE_W-1){v[SAMPLE_W-1]}}};
		end
		return v[SAMPLE_W-1:0];
	endfunction

	always_ff @(posedge clk) begin
		if (resetd) begin
			att_valid <= 1'b0;
			o_valid   <= 1'b0;
		end else begin
			att_valid <= i_valid;
			o_valid   <= att_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (i_valid) begin
			att_data.l <= attenuate(i_mixed.l, i_att);
			att_data.r <= attenuate(i_mixed.r, i_att);
		end
		if (att_valid) begin
			o_audio.l <= saturate(att_data.l);
			o_audio.r <= saturate(att_data.r);
		end
	end

endmodule

// File: src/audio_mixer_top.sv
////////////////////////////////////////////////////////////
// Stereo audio mixer top
// Volume decoder plus stabilize, sum, cross-mix and clamp
// stages with five cycles from input strobe to output strobe
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module audio_mixer_top import audio_mix_pkg::*; (
	input  logic        clk,
	input  logic        resetd,
	input  logic        i_cmd_sel,
	input  logic        i_cmd_strobe,
	input  logic [15:0] i_cmd_data,
	input  logic        i_sample_valid,
	input  stereo_t     i_core,
	input  logic        i_core_signed,
	input  stereo_t     i_host,
	input  mix_mode_e   i_mix,
	output logic        o_sample_valid,
	output stereo_t     o_audio
);

	logic [ATT_W-1:0] att;

	// Stage to stage strobes and payloads
	logic         stab_valid;
	stereo_t      stab_core;
	logic         sum_valid;
	wide_stereo_t sum;
	logic         mix_valid;
	wide_stereo_t mixed;

	volume_cmd_decoder u_decoder (
		.clk          (clk),
		.resetd       (resetd),
		.i_cmd_sel    (i_cmd_sel),
		.i_cmd_strobe (i_cmd_strobe),
		.i_cmd_data   (i_cmd_data),
		.o_att        (att)
	);

	////////////////////////////////////////////////////////////
	// Sample pipeline
	////////////////////////////////////////////////////////////

	sample_stabilizer u_stabilizer (
		.clk     (clk),
		.resetd  (resetd),
		.i_valid (i_sample_valid),
		.i_core  (i_core),
		.o_valid (stab_valid),
		.o_core  (stab_core)
	);

	source_summer u_summer (
		.clk           (clk),
		.resetd        (resetd),
		.i_valid       (stab_valid),
		.i_core        (stab_core),
		.i_core_signed (i_core_signed),
		.i_host        (i_host),
		.o_valid       (sum_valid),
		.o_sum         (sum)
	);

	cross_mixer u_mixer (
		.clk     (clk),
		.resetd  (resetd),
		.i_valid (sum_valid),
		.i_sum   (sum),
		.i_mix   (i_mix),
		.o_valid (mix_valid),
		.o_mixed (mixed)
	);

	volume_clamp u_clamp (
		.clk     (clk),
		.resetd  (resetd),
		.i_valid (mix_valid),
		.i_mixed (mixed),
		.i_att   (att),
		.o_valid (o_sample_valid),
		.o_audio (o_audio)
	);

endmodule

// File: dv/audio_mixer_tb.sv
////////////////////////////////////////////////////////////
// Audio mixer testbench
// Random stimulus against a reference model with outputs
// checked for value and five-cycle latency
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module audio_mixer_tb import audio_mix_pkg::*; ();

	localparam int N_SUM     = 12;
	localparam int N_MIX     = 10;
	localparam int N_VOL     = 2;
	localparam int N_B2B     = 6;
	localparam int PAIR_CYC  = 4;
	localparam int DRAIN_CYC = 10;
	localparam int FRAME_CYC = 8;
	localparam int VOL_CYC   = FRAME_CYC + N_VOL * PAIR_CYC + DRAIN_CYC;
	// Sum of test lengths plus margin
	localparam int MAX_CYCLES = 2 * (N_SUM * PAIR_CYC + DRAIN_CYC) + 14 + DRAIN_CYC
		+ 4 * (N_MIX * PAIR_CYC + DRAIN_CYC) + 22 * VOL_CYC + 2 * PAIR_CYC + DRAIN_CYC
		+ 2 * N_B2B + DRAIN_CYC + 100;

	logic        clk;
	logic        resetd;
	logic        i_cmd_sel;
	logic        i_cmd_strobe;
	logic [15:0] i_cmd_data;
	logic        i_sample_valid;
	stereo_t     i_core;
	logic        i_core_signed;
	stereo_t     i_host;
	mix_mode_e   i_mix;
	logic        o_sample_valid;
	stereo_t     o_audio;

	// Reference model state
	stereo_t          m_prev;
	stereo_t          m_held;
	logic [ATT_W-1:0] m_att;
	logic [7:0]       frame_op;
	logic             frame_open;

	logic [31:0] rng;
	string       test_name;
	logic [31:0] exp_q[$];
	int          in_cyc_q[$];
	int          cycle = 0;
	int          errors = 0;
	int          checks = 0;

	audio_mixer_top UUT (
		.clk            (clk),
		.resetd         (resetd),
		.i_cmd_sel      (i_cmd_sel),
		.i_cmd_strobe   (i_cmd_strobe),
		.i_cmd_data     (i_cmd_data),
		.i_sample_valid (i_sample_valid),
		.i_core         (i_core),
		.i_core_signed  (i_core_signed),
		.i_host         (i_host),
		.i_mix          (i_mix),
		.o_sample_valid (o_sample_valid),
		.o_audio        (o_audio)
	);

	initial begin
		clk = 1'b0;
	end

	always #20 clk = ~clk;

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [15:0] rand16();
		rng = lcg_next(rng);
		return rng[31:16];
	endfunction

	// Keep 17 bits and sign-extend back to int
	function automatic int wrap17(input int x);
		logic signed [16:0] t;
		t = x[16:0];
		return int'(t);
	endfunction

	function automatic int widen_core(input logic [15:0] v, input logic sgn);
		if (sgn) begin
			return int'($signed(v));
		end
		return int'(v >> 1);
	endfunction

	function automatic int blend(input int own, input int opp, input mix_mode_e mode);
		int half;
		int res;
		half = opp >>> 1;
		case (mode)
			MIX_QUARTER: res = own - (own >>> 3) + (half >>> 2);
			MIX_HALF:    res = own - (own >>> 2) + (half >>> 1);
			MIX_MONO:    res = (own >>> 1) + half;
			default:     res = own;
		endcase
		return wrap17(res);
	endfunction

	function automatic logic [15:0] level(input int v, input logic [ATT_W-1:0] att);
		int a;
		if (att[4]) begin
			a = 0;
		end else begin
			a = v >>> att[3:0];
		end
		if (a > 32767) begin
			return 16'h7FFF;
		end
		if (a < -32768) begin
			return 16'h8000;
		end
		return a[15:0];
	endfunction

	function automatic stereo_t ref_output(input stereo_t core, input stereo_t host,
		input logic sgn, input mix_mode_e mode, input logic [ATT_W-1:0] att);
		int      sum_l;
		int      sum_r;
		stereo_t res;
		sum_l = widen_core(core.l, sgn) + int'($signed(host.l));
		sum_r = widen_core(core.r, sgn) + int'($signed(host.r));
		res.l = level(blend(sum_l, sum_r, mode), att);
		res.r = level(blend(sum_r, sum_l, mode), att);
		return res;
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Stimulus tasks
	////////////////////////////////////////////////////////////

	task automatic step();
		@(posedge clk);
		#1;
	endtask

	task automatic send_sample(input stereo_t core, input stereo_t host, input logic b2b);
		i_sample_valid = 1'b1;
		i_core = core;
		i_host = host;
		// A channel is accepted once it repeats
		if (core.l == m_prev.l) begin
			m_held.l = core.l;
		end
		if (core.r == m_prev.r) begin
			m_held.r = core.r;
		end
		m_prev = core;
		exp_q.push_back(ref_output(m_held, host, i_core_signed, i_mix, m_att));
		in_cyc_q.push_back(cycle);
		step();
		i_sample_valid = 1'b0;
		// Host stays put while the summer picks it up
		if (!b2b) begin
			step();
		end
	endtask

	task automatic send_repeated(input stereo_t core);
		send_sample(core, {rand16(), rand16()}, 1'b0);
		send_sample(core, {rand16(), rand16()}, 1'b0);
	endtask

	task automatic write_word(input logic [15:0] w);
		i_cmd_strobe = 1'b1;
		i_cmd_data = w;
		if (i_cmd_sel) begin
			if (!frame_open) begin
				frame_op = w[7:0];
				frame_open = 1'b1;
			end else if (frame_op == CMD_VOLUME) begin
				m_att = w[ATT_W-1:0];
			end
		end
		step();
		i_cmd_strobe = 1'b0;
		step();
	endtask

	task automatic set_sel(input logic sel);
		i_cmd_sel = sel;
		frame_open = 1'b0;
		step();
	endtask

	task automatic set_volume(input logic [ATT_W-1:0] att);
		set_sel(1'b1);
		write_word({8'h5A, CMD_VOLUME});
		write_word({11'h3C5, att});
		set_sel(1'b0);
	endtask

	task automatic drain();
		while (exp_q.size() != 0) begin
			step();
		end
		step();
		step();
	endtask

	////////////////////////////////////////////////////////////
	// Output checker and cycle limit
	////////////////////////////////////////////////////////////

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= MAX_CYCLES) begin
			$display("Timeout after %0d cycles, %0d samples pending", cycle, exp_q.size());
			$display("Done: errors found");
			$finish;
		end else if (!resetd && o_sample_valid) begin
			if (exp_q.size() == 0) begin
				errors++;
				$display("Output strobe at cycle %0d with no sample pending", cycle);
			end else begin
				check_value(test_name, exp_q.pop_front(), o_audio);
				check_value({test_name, " latency"}, in_cyc_q.pop_front() + 5, cycle);
			end
		end
	end

	initial begin
		stereo_t v;
		stereo_t h;
		rng = 32'h7d3a59b8;
		m_prev = '0;
		m_held = '0;
		m_att = '0;
		frame_op = '0;
		frame_open = 1'b0;
		test_name = "reset";
		resetd = 1'b1;
		i_cmd_sel = 1'b0;
		i_cmd_strobe = 1'b0;
		i_cmd_data = '0;
		i_sample_valid = 1'b0;
		i_core = '0;
		i_core_signed = 1'b1;
		i_host = '0;
		i_mix = MIX_NONE;
		repeat (2) @(posedge clk);
		#1;
		resetd = 1'b0;
		// No output strobe expected while idle
		repeat (6) step();

		test_name = "sum";
		for (int s = 0; s < 2; s++) begin
			i_core_signed = (s == 0);
			for (int n = 0; n < N_SUM; n++) begin
				send_repeated({rand16(), rand16()});
			end
			drain();
		end

		// One-strobe spikes must not reach the output
		test_name = "glitch";
		i_core_signed = 1'b1;
		h = '0;
		v = {16'h1234, 16'h4321};
		send_sample(v, h, 1'b0);
		send_sample(v, h, 1'b0);
		send_sample({16'h7F00, 16'h8100}, h, 1'b0);
		send_sample(v, h, 1'b0);
		send_sample({16'h0F0F, v.r}, h, 1'b0);
		send_sample({16'h2222, 16'h3333}, h, 1'b0);
		send_sample({16'h2222, 16'h3333}, h, 1'b0);
		drain();

		test_name = "mix";
		for (int m = 0; m < 4; m++) begin
			i_mix = mix_mode_e'(m);
			for (int n = 0; n < N_MIX; n++) begin
				send_repeated({rand16(), rand16()});
			end
			drain();
		end
		i_mix = MIX_NONE;

		test_name = "volume";
		for (int a = 0; a <= 16; a++) begin
			set_volume(a[ATT_W-1:0]);
			for (int n = 0; n < N_VOL; n++) begin
				send_repeated({rand16(), rand16()});
			end
			drain();
		end
		test_name = "volume other";
		set_volume(5'd3);
		set_sel(1'b1);
		write_word(16'h0027);
		write_word(16'h0009);
		set_sel(1'b0);
		// Deselected words
		write_word({8'h00, CMD_VOLUME});
		write_word(16'h000C);
		for (int n = 0; n < N_VOL; n++) begin
			send_repeated({rand16(), rand16()});
		end
		drain();
		test_name = "volume multi";
		set_sel(1'b1);
		write_word(16'h0026);
		write_word(16'h0002);
		write_word(16'h0007);
		set_sel(1'b0);
		for (int n = 0; n < N_VOL; n++) begin
			send_repeated({rand16(), rand16()});
		end
		drain();
		set_volume('0);

		test_name = "saturation";
		i_mix = MIX_MONO;
		send_sample({16'h7000, 16'h7000}, {16'h7000, 16'h7000}, 1'b0);
		send_sample({16'h7000, 16'h7000}, {16'h7000, 16'h7000}, 1'b0);
		send_sample({16'h9000, 16'h9000}, {16'h9000, 16'h9000}, 1'b0);
		send_sample({16'h9000, 16'h9000}, {16'h9000, 16'h9000}, 1'b0);
		drain();

		// Strobes on consecutive cycles with host held constant
		test_name = "back-to-back";
		i_mix = MIX_HALF;
		h = {rand16(), rand16()};
		for (int n = 0; n < N_B2B; n++) begin
			v = {rand16(), rand16()};
			send_sample(v, h, 1'b1);
			send_sample(v, h, 1'b1);
		end
		drain();

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

// File: sim.f
src/audio_mix_pkg.sv
src/volume_cmd_decoder.sv
src/sample_stabilizer.sv
src/source_summer.sv
src/cross_mixer.sv
src/volume_clamp.sv
src/audio_mixer_top.sv
dv/audio_mixer_tb.sv
